//--- Makefile
# Verilator build and run of the register file testbench

VERILATOR ?= verilator
TOP       ?= tb_register_file
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
rf_pkg.sv
rf_bank_decode.sv
register_file_bank.sv
rf_operand_collector.sv
register_file.sv
rf_checker.sv
tb_register_file.sv

//--- register_file.sv
/* Top level of the banked warp register file. Decode stage, four banks and
   the operand collector, with a masked write port and an operand issue port. */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import rf_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Masked write port
    input  logic       write_valid_i,
    output logic       write_ready_o,
    input  reg_addr_t  write_addr_i,
    input  lane_mask_t write_mask_i,
    input  warp_data_t write_data_i,
    // Issue port
    input  logic       issue_valid_i,
    output logic       issue_ready_o,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  instr_tag_t issue_tag_i,
    // Operand output, no back-pressure
    output logic       operands_valid_o,
    output instr_tag_t operands_tag_o,
    output warp_data_t operand_a_o,
    output warp_data_t operand_b_o
);

    // ##############################
    // Decode to banks
    // ##############################

    logic       [NUM_BANKS-1:0] bank_wr_valid;
    row_addr_t  [NUM_BANKS-1:0] bank_wr_row;
    lane_mask_t [NUM_BANKS-1:0] bank_wr_mask;
    warp_data_t [NUM_BANKS-1:0] bank_wr_data;
    logic       [NUM_BANKS-1:0] bank_rd_valid;
    row_addr_t  [NUM_BANKS-1:0] bank_rd_row;
    bank_tag_t  [NUM_BANKS-1:0] bank_rd_tag;

    // Banks to collector
    logic       [NUM_BANKS-1:0] resp_valid;
    bank_tag_t  [NUM_BANKS-1:0] resp_tag;
    warp_data_t [NUM_BANKS-1:0] resp_data;

    rf_bank_decode u_decode (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .write_valid_i   (write_valid_i),
        .write_ready_o   (write_ready_o),
        .write_addr_i    (write_addr_i),
        .write_mask_i    (write_mask_i),
        .write_data_i    (write_data_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_src_a_i   (issue_src_a_i),
        .issue_src_b_i   (issue_src_b_i),
        .issue_tag_i     (issue_tag_i),
        .bank_wr_valid_o (bank_wr_valid),
        .bank_wr_row_o   (bank_wr_row),
        .bank_wr_mask_o  (bank_wr_mask),
        .bank_wr_data_o  (bank_wr_data),
        .bank_rd_valid_o (bank_rd_valid),
        .bank_rd_row_o   (bank_rd_row),
        .bank_rd_tag_o   (bank_rd_tag)
    );

    // ##############################
    // Banks
    // ##############################

    // Bank index is the low bits of the register number
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
        register_file_bank u_bank (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .write_valid_i (bank_wr_valid[b]),
            .write_row_i   (bank_wr_row[b]),
            .write_mask_i  (bank_wr_mask[b]),
            .write_data_i  (bank_wr_data[b]),
            .read_valid_i  (bank_rd_valid[b]),
            .read_row_i    (bank_rd_row[b]),
            .read_tag_i    (bank_rd_tag[b]),
            .read_valid_o  (resp_valid[b]),
            .read_tag_o    (resp_tag[b]),
            .read_data_o   (resp_data[b])
        );
    end

    // Pairs A and B per instruction
    rf_operand_collector u_collector (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .resp_valid_i     (resp_valid),
        .resp_tag_i       (resp_tag),
        .resp_data_i      (resp_data),
        .operands_valid_o (operands_valid_o),
        .operands_tag_o   (operands_tag_o),
        .operand_a_o      (operand_a_o),
        .operand_b_o      (operand_b_o)
    );

endmodule

`default_nettype wire

//--- register_file_bank.sv
/* One single-port bank of the warp register file. Writes only the enabled
   lanes of a row and returns a read one cycle later with its tag. */
`timescale 1ns/1ps
`default_nettype none

module register_file_bank
    import rf_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Masked write
    input  logic       write_valid_i,
    input  row_addr_t  write_row_i,
    input  lane_mask_t write_mask_i,
    input  warp_data_t write_data_i,
    // Read request
    input  logic       read_valid_i,
    input  row_addr_t  read_row_i,
    input  bank_tag_t  read_tag_i,
    // Read response
    output logic       read_valid_o,
    output bank_tag_t  read_tag_o,
    output warp_data_t read_data_o
);

    // ##############################
    // Local parameters
    // ##############################

    localparam int unsigned BYTE_WIDTH     = 8;
    localparam int unsigned BYTES_PER_LANE = REG_WIDTH / BYTE_WIDTH;
    // One enable per byte of the warp register
    localparam int unsigned BE_WIDTH       = LANES * BYTES_PER_LANE;

    typedef logic [BE_WIDTH-1:0] byte_en_t;

    // ##############################
    // Signals
    // ##############################

    // Storage, undefined until written
    warp_data_t mem_q [BANK_ROWS];

    // Lane mask widened to bytes
    byte_en_t   write_be;

    // Response registers
    logic       read_valid_q;
    bank_tag_t  read_tag_q;
    warp_data_t read_data_q;

    // ##############################
    // Byte enables
    // ##############################

    // Each lane bit covers all bytes of that lane
    always_comb begin
        for (int lane = 0; lane < LANES; lane++) begin
            write_be[lane*BYTES_PER_LANE +: BYTES_PER_LANE] =
                {BYTES_PER_LANE{write_mask_i[lane]}};
        end
    end

    // ##############################
    // Storage array
    // ##############################

    // Masked write, byte by byte
    always_ff @(posedge clk_i) begin
        if (write_valid_i) begin
            for (int lane = 0; lane < LANES; lane++) begin
                for (int k = 0; k < BYTES_PER_LANE; k++) begin
                    if (write_be[lane*BYTES_PER_LANE + k]) begin
                        mem_q[write_row_i][lane][k*BYTE_WIDTH +: BYTE_WIDTH] <=
                            write_data_i[lane][k*BYTE_WIDTH +: BYTE_WIDTH];
                    end
                end
            end
        end
    end

    // ##############################
    // Read path
    // ##############################

    // Valid one cycle after the request
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_valid_q <= 1'b0;
        end else begin
            read_valid_q <= read_valid_i;
        end
    end

    // Data and tag captured with the request
    always_ff @(posedge clk_i) begin
        if (read_valid_i) begin
            read_tag_q  <= read_tag_i;
            read_data_q <= mem_q[read_row_i];
        end
    end

    // Never a write and a read in one cycle here
    assign read_valid_o = read_valid_q;
    assign read_tag_o   = read_tag_q;
    assign read_data_o  = read_data_q;

endmodule

`default_nettype wire

//--- rf_bank_decode.sv
/* Decode stage of the register file. Maps the write port and the two operand
   reads of an issue onto bank strobes and resolves all bank conflicts. */
`timescale 1ns/1ps
`default_nettype none

module rf_bank_decode
    import rf_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // Masked write port
    input  logic                         write_valid_i,
    output logic                         write_ready_o,
    input  reg_addr_t                    write_addr_i,
    input  lane_mask_t                   write_mask_i,
    input  warp_data_t                   write_data_i,
    // Issue port
    input  logic                         issue_valid_i,
    output logic                         issue_ready_o,
    input  reg_addr_t                    issue_src_a_i,
    input  reg_addr_t                    issue_src_b_i,
    input  instr_tag_t                   issue_tag_i,
    // Per-bank strobes
    output logic       [NUM_BANKS-1:0]   bank_wr_valid_o,
    output row_addr_t  [NUM_BANKS-1:0]   bank_wr_row_o,
    output lane_mask_t [NUM_BANKS-1:0]   bank_wr_mask_o,
    output warp_data_t [NUM_BANKS-1:0]   bank_wr_data_o,
    output logic       [NUM_BANKS-1:0]   bank_rd_valid_o,
    output row_addr_t  [NUM_BANKS-1:0]   bank_rd_row_o,
    output bank_tag_t  [NUM_BANKS-1:0]   bank_rd_tag_o
);

    // ##############################
    // Address split
    // ##############################

    bank_sel_t  wr_bank;
    row_addr_t  wr_row;
    bank_sel_t  a_bank;
    row_addr_t  a_row;
    bank_sel_t  b_bank;
    row_addr_t  b_row;
    logic       same_bank;
    logic       write_fire;
    logic       issue_fire;

    // Deferred B read of a same-bank pair
    logic       pend_valid_q;
    bank_sel_t  pend_bank_q;
    row_addr_t  pend_row_q;
    instr_tag_t pend_tag_q;

    assign wr_bank   = write_addr_i[BANK_BITS-1:0];
    assign wr_row    = write_addr_i[BANK_BITS +: ROW_BITS];
    assign a_bank    = issue_src_a_i[BANK_BITS-1:0];
    assign a_row     = issue_src_a_i[BANK_BITS +: ROW_BITS];
    assign b_bank    = issue_src_b_i[BANK_BITS-1:0];
    assign b_row     = issue_src_b_i[BANK_BITS +: ROW_BITS];
    // Also true when A and B name one register
    assign same_bank = (a_bank == b_bank);

    // ##############################
    // Arbitration
    // ##############################

    // Pending B owns its bank this cycle
    assign write_ready_o = !(pend_valid_q && (wr_bank == pend_bank_q));
    // Pending B blocks issue, then any write into an operand bank
    assign issue_ready_o = !pend_valid_q &&
                           !(write_valid_i && ((wr_bank == a_bank) || (wr_bank == b_bank)));

    assign write_fire = write_valid_i && write_ready_o;
    assign issue_fire = issue_valid_i && issue_ready_o;

    // Fan-out to the banks
    always_comb begin
        bank_wr_valid_o = '0;
        bank_rd_valid_o = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            // Write payload broadcast, strobe picks the bank
            bank_wr_row_o[b]  = wr_row;
            bank_wr_mask_o[b] = write_mask_i;
            bank_wr_data_o[b] = write_data_i;
            bank_rd_row_o[b]  = '0;
            bank_rd_tag_o[b]  = '0;
        end

        if (write_fire) begin
            bank_wr_valid_o[wr_bank] = 1'b1;
        end

        // Second half of a conflicting pair
        if (pend_valid_q) begin
            bank_rd_valid_o[pend_bank_q] = 1'b1;
            bank_rd_row_o[pend_bank_q]   = pend_row_q;
            bank_rd_tag_o[pend_bank_q]   = {pend_tag_q, SLOT_B};
        end

        // A always goes out in the accept cycle
        if (issue_fire) begin
            bank_rd_valid_o[a_bank] = 1'b1;
            bank_rd_row_o[a_bank]   = a_row;
            bank_rd_tag_o[a_bank]   = {issue_tag_i, SLOT_A};
            // B too unless it shares the bank
            if (!same_bank) begin
                bank_rd_valid_o[b_bank] = 1'b1;
                bank_rd_row_o[b_bank]   = b_row;
                bank_rd_tag_o[b_bank]   = {issue_tag_i, SLOT_B};
            end
        end
    end

    // ##############################
    // Pending B register
    // ##############################

    // Lives for exactly one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_valid_q <= 1'b0;
        end else begin
            pend_valid_q <= issue_fire && same_bank;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_fire) begin
            pend_bank_q <= b_bank;
            pend_row_q  <= b_row;
            pend_tag_q  <= issue_tag_i;
        end
    end

endmodule

`default_nettype wire

//--- rf_checker.sv
/* Testbench checker for the register file. Mirrors accepted writes in a model
   and compares every operand pulse, in order, with the expected pair. */
`timescale 1ns/1ps
`default_nettype none

module rf_checker
    import rf_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       write_valid_i,
    input  logic       write_ready_i,
    input  reg_addr_t  write_addr_i,
    input  lane_mask_t write_mask_i,
    input  warp_data_t write_data_i,
    input  logic       issue_valid_i,
    input  logic       issue_ready_i,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  instr_tag_t issue_tag_i,
    input  logic       operands_valid_i,
    input  instr_tag_t operands_tag_i,
    input  warp_data_t operand_a_i,
    input  warp_data_t operand_b_i,
    output int         error_count_o,
    output int         check_count_o,
    output int         outstanding_o
);

    // Register contents as the DUT should hold them
    warp_data_t model [NUM_REGS];

    // Expected pulses, oldest first
    instr_tag_t exp_tag_q [$];
    warp_data_t exp_a_q [$];
    warp_data_t exp_b_q [$];
    int         due_q [$];

    int         cycle_count;
    int         errors;
    int         checks;
    warp_data_t exp_a;
    warp_data_t exp_b;

    // Deferred B read the DUT still owes this cycle
    logic       pend_exp;
    bank_sel_t  pend_bank_exp;
    logic       exp_wready;

    // ##############################
    // Reference model
    // ##############################

    // Operands as the model stands before this edge's write
    function automatic void expected_operands(input reg_addr_t src_a, input reg_addr_t src_b,
                                              output warp_data_t op_a, output warp_data_t op_b);
        op_a = model[src_a];
        op_b = model[src_b];
    endfunction

    // Enabled lanes take new data, the rest keep theirs
    function automatic warp_data_t merge_lanes(input warp_data_t old_data,
                                               input warp_data_t new_data,
                                               input lane_mask_t mask);
        warp_data_t result;
        result = old_data;
        for (int l = 0; l < LANES; l++) begin
            if (mask[l]) result[l] = new_data[l];
        end
        return result;
    endfunction

    task automatic compare(input string name, input warp_data_t expected,
                           input warp_data_t actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%h got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic drop_oldest();
        void'(exp_tag_q.pop_front());
        void'(exp_a_q.pop_front());
        void'(exp_b_q.pop_front());
        void'(due_q.pop_front());
    endtask

    // ##############################
    // Compare process
    // ##############################

    initial begin
        cycle_count = 0;
        errors      = 0;
        checks      = 0;
        pend_exp    = 1'b0;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (rst_n_i) begin
            // Pulse belongs to the oldest outstanding instruction
            if (operands_valid_i) begin
                if (due_q.size() == 0) begin
                    $display("Operand pulse at cycle %0d with nothing outstanding", cycle_count);
                    errors++;
                end else begin
                    if (due_q[0] != cycle_count) begin
                        $display("Operands for tag %0h came at cycle %0d, due at cycle %0d",
                                 exp_tag_q[0], cycle_count, due_q[0]);
                        errors++;
                    end
                    if (operands_tag_i !== exp_tag_q[0]) begin
                        $display("Error operands_tag_o expected 0x%0h got 0x%0h",
                                 exp_tag_q[0], operands_tag_i);
                        errors++;
                    end
                    compare("operand_a_o", exp_a_q[0], operand_a_i);
                    compare("operand_b_o", exp_b_q[0], operand_b_i);
                    checks++;
                    drop_oldest();
                end
            end else if (due_q.size() != 0 && due_q[0] <= cycle_count) begin
                $display("Operands for tag %0h never arrived, due at cycle %0d",
                         exp_tag_q[0], due_q[0]);
                errors++;
                drop_oldest();
            end

            // A write into the bank of a deferred B must wait
            if (write_valid_i) begin
                exp_wready = !(pend_exp && (write_addr_i[BANK_BITS-1:0] == pend_bank_exp));
                if (write_ready_i !== exp_wready) begin
                    $display("Error write_ready_o expected 0x%h got 0x%h",
                             exp_wready, write_ready_i);
                    errors++;
                end
            end

            if (issue_valid_i && issue_ready_i) begin
                expected_operands(issue_src_a_i, issue_src_b_i, exp_a, exp_b);
                exp_tag_q.push_back(issue_tag_i);
                exp_a_q.push_back(exp_a);
                exp_b_q.push_back(exp_b);
                // Same bank means B is read one cycle later
                due_q.push_back(cycle_count +
                    ((issue_src_a_i[BANK_BITS-1:0] == issue_src_b_i[BANK_BITS-1:0]) ? 2 : 1));
            end

            if (write_valid_i && write_ready_i) begin
                model[write_addr_i] = merge_lanes(model[write_addr_i], write_data_i,
                                                  write_mask_i);
            end

            // Same-bank accept leaves B owed for the next cycle
            pend_exp      = issue_valid_i && issue_ready_i &&
                            (issue_src_a_i[BANK_BITS-1:0] == issue_src_b_i[BANK_BITS-1:0]);
            pend_bank_exp = issue_src_b_i[BANK_BITS-1:0];
        end else begin
            pend_exp = 1'b0;
        end
        error_count_o <= errors;
        check_count_o <= checks;
        outstanding_o <= due_q.size();
    end

endmodule

`default_nettype wire

//--- rf_operand_collector.sv
/* Result stage of the register file. Pairs the A and B read responses of
   each instruction and presents both operands in one cycle. */
`timescale 1ns/1ps
`default_nettype none

module rf_operand_collector
    import rf_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // Bank responses
    input  logic       [NUM_BANKS-1:0]   resp_valid_i,
    input  bank_tag_t  [NUM_BANKS-1:0]   resp_tag_i,
    input  warp_data_t [NUM_BANKS-1:0]   resp_data_i,
    // Operand pair, one-cycle pulse
    output logic                         operands_valid_o,
    output instr_tag_t                   operands_tag_o,
    output warp_data_t                   operand_a_o,
    output warp_data_t                   operand_b_o
);

    // Halves arriving this cycle
    logic       a_arr;
    logic       b_arr;
    instr_tag_t b_tag;
    warp_data_t a_data;
    warp_data_t b_data;
    logic       pair_now;
    logic       pair_held;

    // A half waiting for its deferred B
    logic       held_valid_q;
    warp_data_t held_data_q;

    // ##############################
    // Slot sort
    // ##############################

    // At most one A and one B in flight per cycle
    always_comb begin
        a_arr  = 1'b0;
        b_arr  = 1'b0;
        b_tag  = '0;
        a_data = '0;
        b_data = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (resp_valid_i[b]) begin
                if (resp_tag_i[b][0] == SLOT_B) begin
                    b_arr  = 1'b1;
                    b_tag  = resp_tag_i[b][TAG_BITS:1];
                    b_data = resp_data_i[b];
                end else begin
                    a_arr  = 1'b1;
                    a_data = resp_data_i[b];
                end
            end
        end
    end

    // ##############################
    // Pair output
    // ##############################

    // Both halves together, or B meeting the held A
    assign pair_now         = a_arr && b_arr;
    assign pair_held        = b_arr && !a_arr && held_valid_q;
    assign operands_valid_o = pair_now || pair_held;
    // Every pair completes with its B half
    assign operands_tag_o   = b_tag;
    assign operand_a_o      = a_arr ? a_data : held_data_q;
    assign operand_b_o      = b_data;

    // Lone A waits one cycle for B
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            held_valid_q <= 1'b0;
        end else if (a_arr && !b_arr) begin
            held_valid_q <= 1'b1;
        end else if (pair_held) begin
            held_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_arr && !b_arr) begin
            held_data_q <= a_data;
        end
    end

endmodule

`default_nettype wire

//--- rf_pkg.sv
/* Widths, counts and vector types of the banked warp register file.
   Imported with a wildcard by every RTL module and by the testbench. */
`default_nettype none

package rf_pkg;

    // ##############################
    // Geometry
    // ##############################

    // Threads per warp
    localparam int unsigned LANES     = 4;
    // Bits per lane register
    localparam int unsigned REG_WIDTH = 32;
    // Single-port banks
    localparam int unsigned NUM_BANKS = 4;
    // Registers held by one bank
    localparam int unsigned BANK_ROWS = 8;
    // Architectural registers in total
    localparam int unsigned NUM_REGS  = NUM_BANKS * BANK_ROWS;
    localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);
    localparam int unsigned ROW_BITS  = $clog2(BANK_ROWS);
    // Instruction tag width
    localparam int unsigned TAG_BITS  = 4;

    // Operand slot bit, LSB of a bank tag
    localparam logic SLOT_A = 1'b0;
    localparam logic SLOT_B = 1'b1;

    // ##############################
    // Vector types
    // ##############################

    typedef logic [REG_WIDTH-1:0]        lane_data_t;
    typedef lane_data_t [LANES-1:0]      warp_data_t;
    typedef logic [LANES-1:0]            lane_mask_t;
    // Low bits select the bank, high bits the row
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [BANK_BITS-1:0]        bank_sel_t;
    typedef logic [ROW_BITS-1:0]         row_addr_t;
    typedef logic [TAG_BITS-1:0]         instr_tag_t;
    // Instruction tag on top of the slot bit
    typedef logic [TAG_BITS:0]           bank_tag_t;

endpackage

`default_nettype wire

//--- tb_register_file.sv
/* Testbench top for the banked warp register file. Drives writes and issues
   on the falling edge, while rf_checker compares every operand pair. */
`timescale 1ns/1ps
`default_nettype none

module tb_register_file
    import rf_pkg::*;
();

    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned WAIT_LIMIT   = 40;
    localparam int unsigned RNG_SEED     = 15165;
    localparam int unsigned RANDOM_OPS   = 300;

    logic       clk_i;
    logic       rst_n_i;
    logic       write_valid_i;
    logic       write_ready_o;
    reg_addr_t  write_addr_i;
    lane_mask_t write_mask_i;
    warp_data_t write_data_i;
    logic       issue_valid_i;
    logic       issue_ready_o;
    reg_addr_t  issue_src_a_i;
    reg_addr_t  issue_src_b_i;
    instr_tag_t issue_tag_i;
    logic       operands_valid_o;
    instr_tag_t operands_tag_o;
    warp_data_t operand_a_o;
    warp_data_t operand_b_o;

    int         checker_errors;
    int         checks;
    int         outstanding;
    int         tb_errors;
    int         errors_before;
    logic       timed_out;
    instr_tag_t next_tag;

    register_file DUT (.*);

    rf_checker u_checker (
        .clk_i, .rst_n_i, .write_valid_i, .write_addr_i, .write_mask_i, .write_data_i,
        .write_ready_i    (write_ready_o),
        .issue_valid_i, .issue_src_a_i, .issue_src_b_i, .issue_tag_i,
        .issue_ready_i    (issue_ready_o),
        .operands_valid_i (operands_valid_o),
        .operands_tag_i   (operands_tag_o),
        .operand_a_i      (operand_a_o),
        .operand_b_i      (operand_b_o),
        .error_count_o    (checker_errors),
        .check_count_o    (checks),
        .outstanding_o    (outstanding)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ##############################
    // Helpers
    // ##############################

    // Bank is the low bits of the register number
    function automatic bank_sel_t bank_of(input reg_addr_t addr);
        return addr[BANK_BITS-1:0];
    endfunction

    function automatic warp_data_t random_warp();
        warp_data_t w;
        for (int l = 0; l < LANES; l++) w[l] = $urandom;
        return w;
    endfunction

    // Offers a write and an issue together, each held until accepted
    task automatic transfer(input logic do_write, input reg_addr_t waddr,
                            input lane_mask_t wmask, input warp_data_t wdata,
                            input logic do_issue, input reg_addr_t src_a,
                            input reg_addr_t src_b);
        int   waited;
        logic write_done;
        logic issue_done;
        waited        = 0;
        write_valid_i = do_write && !timed_out;
        write_addr_i  = waddr;
        write_mask_i  = wmask;
        write_data_i  = wdata;
        issue_valid_i = do_issue && !timed_out;
        issue_src_a_i = src_a;
        issue_src_b_i = src_b;
        issue_tag_i   = next_tag;
        while (write_valid_i || issue_valid_i) begin
            @(posedge clk_i);
            write_done = write_valid_i && write_ready_o;
            issue_done = issue_valid_i && issue_ready_o;
            // A write into an operand bank goes first
            if (write_valid_i && issue_done &&
                (bank_of(waddr) == bank_of(src_a) || bank_of(waddr) == bank_of(src_b))) begin
                $display("Error issue_ready_o expected 0x0 got 0x1");
                tb_errors++;
            end
            waited++;
            @(negedge clk_i);
            // Deferred B read keeps the next issue out
            if (issue_done && bank_of(src_a) == bank_of(src_b) && issue_ready_o !== 1'b0) begin
                $display("Error issue_ready_o expected 0x0 got 0x%h", issue_ready_o);
                tb_errors++;
            end
            if (write_done) write_valid_i = 1'b0;
            if (issue_done) begin
                issue_valid_i = 1'b0;
                next_tag      = next_tag + instr_tag_t'(1);
            end
            if (waited >= WAIT_LIMIT && (write_valid_i || issue_valid_i)) begin
                $display("Timeout: request not accepted within %0d cycles", WAIT_LIMIT);
                write_valid_i = 1'b0;
                issue_valid_i = 1'b0;
                timed_out     = 1'b1;
                tb_errors++;
            end
        end
    endtask

    // Waits for all operand pulses, then reports the test
    task automatic finish_test(input int num, input string name);
        int waited;
        waited = 0;
        while (outstanding != 0 && !timed_out) begin
            @(negedge clk_i);
            waited++;
            if (waited >= WAIT_LIMIT && outstanding != 0) begin
                $display("Timeout: %0d instructions never got their operands", outstanding);
                timed_out = 1'b1;
                tb_errors++;
            end
        end
        $display("Test %0d %s finished with %0d errors", num, name,
                 tb_errors + checker_errors - errors_before);
        errors_before = tb_errors + checker_errors;
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin : stimulus
        reg_addr_t   a;
        reg_addr_t   b;
        reg_addr_t   waddr;
        logic        do_w;
        logic        do_i;
        void'($urandom(RNG_SEED));
        rst_n_i       = 1'b0;
        write_valid_i = 1'b0;
        write_addr_i  = '0;
        write_mask_i  = '0;
        write_data_i  = '0;
        issue_valid_i = 1'b0;
        issue_src_a_i = '0;
        issue_src_b_i = '0;
        issue_tag_i   = '0;
        next_tag      = '0;
        tb_errors     = 0;
        errors_before = 0;
        timed_out     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        // Fill every register, then read cross-bank pairs
        for (int r = 0; r < NUM_REGS; r++) begin
            transfer(1'b1, reg_addr_t'(r), '1, random_warp(), 1'b0, '0, '0);
        end
        for (int i = 0; i < 24; i++) begin
            a = reg_addr_t'($urandom);
            b = {row_addr_t'($urandom), bank_of(a) ^ bank_sel_t'(1 + ($urandom % 3))};
            transfer(1'b0, '0, '0, '0, 1'b1, a, b);
        end
        finish_test(1, "full-mask fill and cross-bank reads");

        // Masked-off lanes must keep the old data
        for (int i = 0; i < 16; i++) begin
            transfer(1'b1, reg_addr_t'($urandom), lane_mask_t'($urandom), random_warp(),
                     1'b0, '0, '0);
        end
        for (int r = 0; r < NUM_REGS; r += 2) begin
            transfer(1'b0, '0, '0, '0, 1'b1, reg_addr_t'(r), reg_addr_t'(r) ^ 5'd1);
        end
        finish_test(2, "partial lane masks");

        // Same bank, every third one the same register
        for (int i = 0; i < 18; i++) begin
            a = reg_addr_t'($urandom);
            b = (i % 3 == 0) ? a : {row_addr_t'($urandom), bank_of(a)};
            transfer(1'b0, '0, '0, '0, 1'b1, a, b);
        end
        finish_test(3, "same-bank pairs");

        // Write into an operand bank offered with the issue
        for (int i = 0; i < 12; i++) begin
            a     = reg_addr_t'($urandom);
            b     = reg_addr_t'($urandom);
            waddr = (i % 2 == 0) ? a : {row_addr_t'($urandom), bank_of(b)};
            transfer(1'b1, waddr, lane_mask_t'($urandom), random_warp(), 1'b1, a, b);
        end
        finish_test(4, "write against issue");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            do_w = ($urandom & 1) != 0;
            do_i = ($urandom & 3) != 0;
            if (do_w || do_i) begin
                transfer(do_w, reg_addr_t'($urandom), lane_mask_t'($urandom), random_warp(),
                         do_i, reg_addr_t'($urandom), reg_addr_t'($urandom));
            end else begin
                @(negedge clk_i);
            end
        end
        finish_test(5, "random writes and issues");

        $display("Tests run: 5, operand pairs checked: %0d, errors: %0d",
                 checks, tb_errors + checker_errors);
        if (tb_errors + checker_errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
